//--- hdl/uartPkg.sv
package uartPkg;

	////////////////////////////////////////////////////////////
	// widths that carry a meaning
	////////////////////////////////////////////////////////////

	typedef logic [7:0] uartByte_t;		// one data byte, bus side and line side
	typedef logic [15:0] baudDiv_t;		// tick period is divisor + 1 clocks
	typedef logic [1:0] regAddr_t;		// wishbone word address

	// register map
	localparam regAddr_t addrData = 2'd0;		// tx push / rx holding reg
	localparam regAddr_t addrStatus = 2'd1;		// status word, read clears rxError
	localparam regAddr_t addrDivLo = 2'd2;		// divisor bits 7..0
	localparam regAddr_t addrDivHi = 2'd3;		// divisor bits 15..8

	////////////////////////////////////////////////////////////
	// status word, rxError ends up in bit 0
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic txFull;		// fifo cannot take another byte
		logic txEmpty;		// nothing waiting in the fifo
		logic txBusy;		// transmitter is inside a frame
		logic rxValid;		// holding reg has an unread byte
		logic rxError;		// sticky, framing error or overrun
	} uartStatus_t;

	// frame phases, same encoding for both directions
	typedef enum logic [1:0] {
		idle = 2'b00,
		start = 2'b01,
		data = 2'b10,
		stop = 2'b11
	} lineState_t;

endpackage

//--- hdl/baudTickGen.sv
`timescale 1ns/1ps

module baudTickGen
(
	input logic clk,
	input logic reset,
	input uartPkg::baudDiv_t divisor,
	output logic sTick
);

	uartPkg::baudDiv_t count;	// clocks left before the next tick

	// free running down-counter
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (count == '0)
			count <= divisor;	// reload, a new divisor only lands here
		else
			count <= count - 1'b1;
	end

	// one clock wide, every clock when divisor is 0
	assign sTick = (count == '0);

endmodule

//--- hdl/txFifo.sv
`timescale 1ns/1ps

module txFifo #(
	parameter int fifoAddrLen = 2
)
(
	input logic clk,
	input logic reset,
	input logic push,
	input uartPkg::uartByte_t pushData,
	input logic pop,
	output uartPkg::uartByte_t headData,
	output logic full,
	output logic empty
);

	localparam int depth = 1 << fifoAddrLen;

	uartPkg::uartByte_t mem [depth];		// byte storage
	logic [fifoAddrLen-1:0] wrPtr, rdPtr;	// wrap on their own, depth is a power of 2
	logic [fifoAddrLen:0] count;			// occupancy, 0..depth
	logic doWrite, doRead;

	assign doWrite = push && !full;
	assign doRead = pop && !empty;

	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= pushData;
	end

	// pointers and occupancy
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	assign full = (count == (fifoAddrLen + 1)'(depth));
	assign empty = (count == '0);
	assign headData = mem[rdPtr];	// fall-through, valid while !empty

	// the bus side drops writes when full, the transmitter only pops on !empty
	assert property (@(posedge clk) disable iff (reset) full |-> !push);
	assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

//--- hdl/uartTransmitter.sv
`timescale 1ns/1ps

module uartTransmitter #(
	parameter int stopTicks = 16
)
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txStart,
	input uartPkg::uartByte_t din,
	output logic dataTaken,
	output logic txBusy,
	output logic tx
);

	localparam int cntW = $clog2(stopTicks + 1);
	localparam logic [cntW-1:0] lastTick = cntW'(15);			// 16 ticks per bit
	localparam logic [cntW-1:0] lastStop = cntW'(stopTicks - 1);

	uartPkg::lineState_t stateReg, stateNext;
	logic [cntW-1:0] sReg, sNext;		// tick counter inside a bit
	logic [2:0] nReg, nNext;			// data bit index
	uartPkg::uartByte_t bReg, bNext;	// shift reg, lsb goes out first
	logic txReg, txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;		// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		dataTaken = 1'b0;
		case (stateReg)
			uartPkg::idle:
			begin
				txNext = 1'b1;
				// leave on a tick so the start bit is exactly 16 ticks
				if (txStart && sTick)
				begin
					dataTaken = 1'b1;	// pops the fifo head
					bNext = din;		// byte latched here, not in start
					sNext = '0;
					stateNext = uartPkg::start;
				end
			end
			uartPkg::start:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						nNext = '0;
						stateNext = uartPkg::data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::data:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						bNext = bReg >> 1;	// next bit into position 0
						if (nReg == 3'd7)
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == lastStop)
						stateNext = uartPkg::idle;	// 1, 1.5 or 2 stop bits
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign txBusy = (stateReg != uartPkg::idle);
	assign tx = txReg;

	assert property (@(posedge clk) disable iff (reset) (stateReg == uartPkg::idle) |-> tx);
	assert property (@(posedge clk) disable iff (reset)
		dataTaken |-> (stateReg == uartPkg::idle) && txStart);

endmodule

//--- hdl/uartReceiver.sv
`timescale 1ns/1ps

module uartReceiver #(
	parameter int stopTicks = 16
)
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output logic rxDone,
	output logic frameErr,
	output uartPkg::uartByte_t rxData
);

	// from the last data sample to the middle of the stop time
	localparam int stopSample = 8 + stopTicks / 2;
	localparam int cntW = $clog2(stopSample + 1);
	localparam logic [cntW-1:0] startMid = cntW'(7);
	localparam logic [cntW-1:0] lastTick = cntW'(15);
	localparam logic [cntW-1:0] stopMid = cntW'(stopSample - 1);

	logic rxMeta, rxSync, rxLast;		// 2-flop sync plus edge history
	uartPkg::lineState_t stateReg, stateNext;
	logic [cntW-1:0] sReg, sNext;
	logic [2:0] nReg, nNext;
	uartPkg::uartByte_t bReg, bNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDone = 1'b0;
		frameErr = 1'b0;
		case (stateReg)
			uartPkg::idle:
			begin
				if (rxLast && !rxSync)		// falling edge only, a held-low line waits
				begin
					sNext = '0;
					stateNext = uartPkg::start;
				end
			end
			uartPkg::start:
			begin
				if (sTick)
				begin
					if (sReg == startMid)
					begin
						sNext = '0;
						nNext = '0;
						// glitch if the line is back high by mid start bit
						stateNext = rxSync ? uartPkg::idle : uartPkg::data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::data:
			begin
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						bNext = {rxSync, bReg[7:1]};	// lsb arrives first
						if (nReg == 3'd7)
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stop:
			begin
				if (sTick)
				begin
					if (sReg == stopMid)
					begin
						rxDone = 1'b1;			// sender still in its stop bit
						frameErr = !rxSync;
						stateNext = uartPkg::idle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign rxData = bReg;

	assert property (@(posedge clk) disable iff (reset) frameErr |-> rxDone);

endmodule

//--- hdl/wbUartRegs.sv
`timescale 1ns/1ps

module wbUartRegs
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input uartPkg::regAddr_t adr,
	input uartPkg::uartByte_t datWr,
	output uartPkg::uartByte_t datRd,
	output logic ack,
	output logic push,
	output uartPkg::uartByte_t pushData,
	input logic full,
	input logic empty,
	input logic txBusy,
	output uartPkg::baudDiv_t divisor,
	input logic rxDone,
	input logic frameErr,
	input uartPkg::uartByte_t rxData
);

	logic access, wrAccess, rdAccess;
	logic dataRead, statusRead;
	logic rxValid, rxError;
	uartPkg::uartByte_t rxHold;		// single holding reg, no rx fifo
	uartPkg::uartStatus_t status;

	// request seen, ack rises on this edge; blocked while ack is high
	assign access = cyc && stb && !ack;
	assign wrAccess = access && we;
	assign rdAccess = access && !we;
	assign dataRead = rdAccess && (adr == uartPkg::addrData);
	assign statusRead = rdAccess && (adr == uartPkg::addrStatus);

	assign push = wrAccess && (adr == uartPkg::addrData) && !full;	// full drops the byte
	assign pushData = datWr;

	assign status.txFull = full;
	assign status.txEmpty = empty;
	assign status.txBusy = txBusy;
	assign status.rxValid = rxValid;
	assign status.rxError = rxError;

	////////////////////////////////////////////////////////////
	// control regs and sticky flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			divisor <= '0;
			rxValid <= 1'b0;
			rxError <= 1'b0;
		end
		else
		begin
			ack <= access;
			if (wrAccess && (adr == uartPkg::addrDivLo))
				divisor[7:0] <= datWr;
			if (wrAccess && (adr == uartPkg::addrDivHi))
				divisor[15:8] <= datWr;
			if (rxDone)
				rxValid <= 1'b1;			// new byte beats a read on the same edge
			else if (dataRead)
				rxValid <= 1'b0;
			if (frameErr || (rxDone && rxValid && !dataRead))
				rxError <= 1'b1;			// framing error or overrun
			else if (statusRead)
				rxError <= 1'b0;
		end
	end

	// read data is captured on the ack edge, before any clear
	always_ff @(posedge clk)
	begin
		if (rxDone)
			rxHold <= rxData;	// an overrun overwrites
		if (rdAccess)
		begin
			case (adr)
				uartPkg::addrData: datRd <= rxHold;
				uartPkg::addrStatus: datRd <= {3'b000, status};
				uartPkg::addrDivLo: datRd <= divisor[7:0];
				uartPkg::addrDivHi: datRd <= divisor[15:8];
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) ack |-> $past(cyc && stb));

endmodule

//--- hdl/uartTop.sv
`timescale 1ns/1ps

module uartTop #(
	parameter int fifoAddrLen = 2,		// 4 entry tx fifo
	parameter int stopTicks = 16		// 16/24/32 for 1/1.5/2 stop bits
)
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input uartPkg::regAddr_t adr,
	input uartPkg::uartByte_t datWr,
	output uartPkg::uartByte_t datRd,
	output logic ack,
	input logic rx,
	output logic tx
);

	logic push, pop, full, empty, txBusy;
	logic sTick, rxDone, frameErr;
	uartPkg::uartByte_t pushData, headData, rxData;
	uartPkg::baudDiv_t divisor;

	wbUartRegs wbUartRegs_inst (
		.clk(clk), .reset(reset),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datWr(datWr), .datRd(datRd), .ack(ack),
		.push(push), .pushData(pushData),
		.full(full), .empty(empty), .txBusy(txBusy),
		.divisor(divisor),
		.rxDone(rxDone), .frameErr(frameErr), .rxData(rxData)
	);

	txFifo #(.fifoAddrLen(fifoAddrLen)) txFifo_inst (
		.clk(clk), .reset(reset),
		.push(push), .pushData(pushData),
		.pop(pop), .headData(headData),		// pop is the transmitter's take strobe
		.full(full), .empty(empty)
	);

	baudTickGen baudTickGen_inst (
		.clk(clk), .reset(reset), .divisor(divisor), .sTick(sTick)
	);

	uartTransmitter #(.stopTicks(stopTicks)) uartTransmitter_inst (
		.clk(clk), .reset(reset), .sTick(sTick),
		.txStart(!empty), .din(headData),	// any queued byte starts a frame
		.dataTaken(pop), .txBusy(txBusy), .tx(tx)
	);

	uartReceiver #(.stopTicks(stopTicks)) uartReceiver_inst (
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDone(rxDone), .frameErr(frameErr), .rxData(rxData)
	);

endmodule

//--- sim/uartTopTb.sv
`timescale 1ns/1ps

module uartTopTb;

	localparam int clkPeriod = 20;
	localparam int ackLimit = 16;			// clocks for one bus ack
	localparam int pollLimit = 20000;		// status polls before giving up
	localparam int clkLimit = 20000;		// clocks for a tx edge
	localparam int runLimit = 500000;		// whole run

	// status bits in the order of the package struct
	localparam logic [4:0] txFullBit = 5'b10000;
	localparam logic [4:0] txEmptyBit = 5'b01000;
	localparam logic [4:0] txBusyBit = 5'b00100;
	localparam logic [4:0] rxValidBit = 5'b00010;
	localparam logic [4:0] rxErrorBit = 5'b00001;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	uartPkg::regAddr_t adr;
	uartPkg::uartByte_t datWr;
	uartPkg::uartByte_t datRd;
	logic ack;
	logic rx;
	logic tx;
	logic loopOn;		// 1 means rx follows tx
	logic lineDrv;		// line driven by the testbench
	int seedResult;

	assign rx = loopOn ? tx : lineDrv;

	uartTop #(.fifoAddrLen(2), .stopTicks(16)) uartTop_inst (
		.clk(clk), .reset(reset),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datWr(datWr), .datRd(datRd), .ack(ack),
		.rx(rx), .tx(tx)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic stopOnTimeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got == exp)
		else
		begin
			$display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Errors found");
			$fatal(1, "check failed");
		end
	endtask

	function automatic uartPkg::uartByte_t randomByte();
		return 8'($urandom());
	endfunction

	////////////////////////////////////////////////////////////
	// wishbone side
	////////////////////////////////////////////////////////////

	task automatic wbWrite(input uartPkg::regAddr_t a, input uartPkg::uartByte_t d);
		int n;
		n = 0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		datWr = d;
		@(negedge clk);
		while (!ack)
		begin
			if (n == ackLimit)
				stopOnTimeout("write ack");
			n++;
			@(negedge clk);
		end
		cyc = 1'b0;		// drop on the ack clock
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbRead(input uartPkg::regAddr_t a, output uartPkg::uartByte_t d);
		int n;
		n = 0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		@(negedge clk);
		while (!ack)
		begin
			if (n == ackLimit)
				stopOnTimeout("read ack");
			n++;
			@(negedge clk);
		end
		d = datRd;		// valid together with ack
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic readStatus(output logic [4:0] st);
		uartPkg::uartByte_t d;
		wbRead(uartPkg::addrStatus, d);
		st = d[4:0];
	endtask

	task automatic setDivisor(input uartPkg::baudDiv_t div);
		wbWrite(uartPkg::addrDivLo, div[7:0]);
		wbWrite(uartPkg::addrDivHi, div[15:8]);
	endtask

	// poll until the masked flags match
	task automatic waitStatus(input logic [4:0] mask, input logic [4:0] want,
		input string what, output logic [4:0] st);
		int n;
		n = 0;
		readStatus(st);
		while ((st & mask) != want)
		begin
			if (n == pollLimit)
				stopOnTimeout(what);
			n++;
			readStatus(st);
		end
	endtask

	task automatic waitTxIdle();
		logic [4:0] st;
		waitStatus(txEmptyBit | txBusyBit, txEmptyBit, "transmitter idle", st);
	endtask

	////////////////////////////////////////////////////////////
	// serial line side
	////////////////////////////////////////////////////////////

	// 16 ticks per bit, divisor + 1 clocks per tick
	task automatic sendRawFrame(input uartPkg::uartByte_t d, input logic stopLevel,
		input int div);
		int bitClocks;
		int i;
		bitClocks = 16 * (div + 1);
		@(negedge clk);
		lineDrv = 1'b0;		// start
		repeat (bitClocks) @(negedge clk);
		for (i = 0; i < 8; i++)
		begin
			lineDrv = d[i];		// lsb first
			repeat (bitClocks) @(negedge clk);
		end
		lineDrv = stopLevel;
		repeat (bitClocks) @(negedge clk);
		lineDrv = 1'b1;
	endtask

	task automatic measureStartBit(output int width);
		int n;
		n = 0;
		width = 0;
		while (tx)
		begin
			if (n == clkLimit)
				stopOnTimeout("start bit on tx");
			n++;
			@(negedge clk);
		end
		while (!tx)
		begin
			if (width == clkLimit)
				stopOnTimeout("end of start bit");
			width++;
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic testReset();
		logic [4:0] st;
		readStatus(st);
		checkValue("status", 16'(st), 16'(txEmptyBit));	// only txEmpty
		checkValue("tx", 16'(tx), 16'h0001);
	endtask

	task automatic testLoopback();
		logic [4:0] st;
		uartPkg::uartByte_t b;
		uartPkg::uartByte_t got;
		loopOn = 1'b1;
		setDivisor(16'd3);
		b = randomByte();
		wbWrite(uartPkg::addrData, b);
		waitStatus(rxValidBit, rxValidBit, "looped byte", st);
		wbRead(uartPkg::addrData, got);
		checkValue("datRd", 16'(got), 16'(b));
		readStatus(st);
		checkValue("status.rxValid", 16'(st & rxValidBit), 16'h0000);
		waitTxIdle();
	endtask

	task automatic testBurstFull();
		logic [4:0] st;
		uartPkg::uartByte_t sent [5];
		uartPkg::uartByte_t got;
		int i;
		loopOn = 1'b0;
		lineDrv = 1'b1;
		// long reload first, the burst then lands before the first pop
		wbWrite(uartPkg::addrDivHi, 8'h01);
		setDivisor(16'd15);
		for (i = 0; i < 5; i++)
			sent[i] = randomByte();
		for (i = 0; i < 4; i++)
			wbWrite(uartPkg::addrData, sent[i]);
		readStatus(st);
		checkValue("status.txFull", 16'(st & txFullBit), 16'(txFullBit));
		wbWrite(uartPkg::addrData, sent[4]);	// dropped, still acked
		loopOn = 1'b1;
		for (i = 0; i < 4; i++)
		begin
			waitStatus(rxValidBit, rxValidBit, "burst byte", st);
			wbRead(uartPkg::addrData, got);
			checkValue("datRd", 16'(got), 16'(sent[i]));
		end
		waitTxIdle();
		readStatus(st);
		checkValue("status.rxValid", 16'(st & rxValidBit), 16'h0000);	// fifth never sent
	endtask

	task automatic testFrameError();
		logic [4:0] st;
		uartPkg::uartByte_t b;
		uartPkg::uartByte_t got;
		loopOn = 1'b0;
		b = randomByte();
		sendRawFrame(b, 1'b0, 15);		// low stop bit
		waitStatus(rxValidBit, rxValidBit, "framed byte", st);
		checkValue("status.rxError", 16'(st & rxErrorBit), 16'(rxErrorBit));
		readStatus(st);
		checkValue("status.rxError", 16'(st & rxErrorBit), 16'h0000);	// cleared by the read
		wbRead(uartPkg::addrData, got);
		checkValue("datRd", 16'(got), 16'(b));
	endtask

	task automatic testOverrun();
		logic [4:0] st;
		uartPkg::uartByte_t b0;
		uartPkg::uartByte_t b1;
		uartPkg::uartByte_t got;
		loopOn = 1'b1;
		setDivisor(16'd3);
		b0 = randomByte();
		b1 = randomByte();
		wbWrite(uartPkg::addrData, b0);
		wbWrite(uartPkg::addrData, b1);
		waitStatus(rxErrorBit, rxErrorBit, "overrun flag", st);
		checkValue("status.rxValid", 16'(st & rxValidBit), 16'(rxValidBit));
		wbRead(uartPkg::addrData, got);
		checkValue("datRd", 16'(got), 16'(b1));		// second byte overwrote
		waitTxIdle();
	endtask

	task automatic checkStartWidth(input int div);
		uartPkg::uartByte_t b;
		int width;
		setDivisor(16'(div));
		b = randomByte() | 8'h01;	// lsb high ends the low run
		wbWrite(uartPkg::addrData, b);
		measureStartBit(width);
		checkValue("start bit width", 16'(width), 16'(16 * (div + 1)));
		waitTxIdle();
	endtask

	task automatic testBaudChange();
		loopOn = 1'b1;
		checkStartWidth(1);
		checkStartWidth(7);
	endtask

	////////////////////////////////////////////////////////////
	// run
	////////////////////////////////////////////////////////////

	initial
	begin
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datWr = '0;
		loopOn = 1'b1;
		lineDrv = 1'b1;		// idle line
		reset = 1'b1;
		seedResult = $urandom(32'h18fdbc83);
		repeat (4) @(negedge clk);
		reset = 1'b0;
		testReset();
		testLoopback();
		testBurstFull();
		testFrameError();
		testOverrun();
		testBaudChange();
		$display("No errors");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (runLimit) @(posedge clk);
		$display("run exceeded its clock budget");
		$display("Errors found");
		$fatal(1, "run stopped");
	end

endmodule

//--- sources.f
hdl/uartPkg.sv
hdl/baudTickGen.sv
hdl/txFifo.sv
hdl/uartTransmitter.sv
hdl/uartReceiver.sv
hdl/wbUartRegs.sv
hdl/uartTop.sv
sim/uartTopTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= uartTopTb
FILELIST ?= sources.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
